// ==== common/axil_map_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared widths, address map, response codes and request/response structs
// for the axi4-lite peripheral subsystem
////////////////////////////////////////////////////////////////////////////
package axil_map_pkg;

    // basic bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // axi response codes used here
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_SLAVES = 2;

    // one-hot select, the top bit flags "none selected"
    typedef logic [NUM_SLAVES:0] sel_t;
    localparam int SEL_REG  = 0;
    localparam int SEL_ROM  = 1;
    localparam int SEL_NONE = 2;

    // register bank window, 4 KiB, eight words alias through it
    localparam addr_t REG_BASE = 32'h1000_0000;
    localparam addr_t REG_MASK = 32'hFFFF_F000;

    // identification rom window, same shape
    localparam addr_t ROM_BASE = 32'h2000_0000;
    localparam addr_t ROM_MASK = 32'hFFFF_F000;

    // slave tables, indexed by slave number
    localparam addr_t [NUM_SLAVES-1:0] SLAVE_BASE = {ROM_BASE, REG_BASE};
    localparam addr_t [NUM_SLAVES-1:0] SLAVE_MASK = {ROM_MASK, REG_MASK};

    // per-channel access masks, rom is read-only
    localparam logic [NUM_SLAVES-1:0] READ_ALLOWED  = 2'b11;
    localparam logic [NUM_SLAVES-1:0] WRITE_ALLOWED = 2'b01;

    // rom word i reads back as ROM_TAG + i
    localparam data_t ROM_TAG = 32'hC0DE_0000;

    // word index sits in address bits 4..2
    localparam int WORD_SEL_W = 3;
    localparam int WORD_LSB   = 2;

    ////////////////////////////////////////////////////////////////////////////
    // channel structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
        logic  write;
    } req_t;

    // request after the decode stage, carries its slave select
    typedef struct packed {
        req_t req;
        sel_t sel;
    } dec_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } rsp_t;

endpackage

// ==== hdl/axil_addr_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// registered address decode, matches a request against the slave map and
// holds it with a one-hot slave select for the routing stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_addr_decode
    import axil_map_pkg::*;
#(
    // which slaves this channel may reach
    parameter logic [NUM_SLAVES-1:0] ACCESS_ALLOWED = READ_ALLOWED
) (
    input  logic     clock,
    input  logic     reset,

    // upstream request
    input  logic     i_valid,
    output logic     o_ready,
    input  req_t     i_req,

    // decoded request toward the router
    output logic     o_valid,
    input  logic     i_ready,
    output dec_req_t o_req
);

    ////////////////////////////////////////////////////////////////////////////
    // address match
    ////////////////////////////////////////////////////////////////////////////

    // per-slave hit, only where the channel is allowed
    logic [NUM_SLAVES-1:0] slave_hit;
    sel_t                  sel_next;

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            // bits outside the mask are don't-care
            slave_hit[s] = (((i_req.addr ^ SLAVE_BASE[s]) & SLAVE_MASK[s]) == '0)
                           && ACCESS_ALLOWED[s];
        end
    end

    always_comb begin
        sel_next = '0;
        sel_next[NUM_SLAVES-1:0] = slave_hit;
        // nothing matched, route to the error lane
        sel_next[SEL_NONE] = ~|slave_hit;
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode register
    ////////////////////////////////////////////////////////////////////////////

    // stall only while holding an entry that downstream does not take
    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    // payload loads only on an accepted request
    always_ff @(posedge clock) begin
        if (o_ready && i_valid) begin
            o_req.req <= i_req;
            o_req.sel <= sel_next;
        end
    end

endmodule

// ==== axil_router/axil_router.sv ====
////////////////////////////////////////////////////////////////////////////
// routes decoded read and write requests to the slaves, forms decode
// errors and holds one registered response per channel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_router
    import axil_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,

    // decoded read requests
    input  logic                  i_rd_valid,
    output logic                  o_rd_ready,
    input  dec_req_t              i_rd_req,

    // decoded write requests
    input  logic                  i_wr_valid,
    output logic                  o_wr_ready,
    input  dec_req_t              i_wr_req,

    // read response channel
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output rsp_t                  o_rsp_rd,

    // write response channel
    output logic                  o_bvalid,
    input  logic                  i_bready,
    output resp_t                 o_bresp,

    // slave side
    output logic                  o_reg_wr_en,
    output logic                  o_reg_rd_en,
    output logic                  o_rom_rd_en,
    output logic [WORD_SEL_W-1:0] o_word_sel,
    output data_t                 o_wdata,
    output strb_t                 o_wstrb,
    input  data_t                 i_reg_rdata,
    input  data_t                 i_rom_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////////////

    logic rd_free;
    logic rd_take;
    logic rd_busy;
    sel_t rd_pend_sel;

    // response register is free or drains this cycle
    assign rd_free    = !o_rvalid || i_rready;
    assign o_rd_ready = rd_free;
    assign rd_take    = i_rd_valid && rd_free;

    // slave enables, none for the error lane
    assign o_reg_rd_en = rd_take && i_rd_req.sel[SEL_REG];
    assign o_rom_rd_en = rd_take && i_rd_req.sel[SEL_ROM];
    assign rd_busy     = o_reg_rd_en || o_rom_rd_en;

    always_ff @(posedge clock) begin
        if (reset) begin
            o_rvalid <= 1'b0;
        end else if (rd_free) begin
            o_rvalid <= rd_take;
        end
    end

    // remember which slave will hold the read data
    always_ff @(posedge clock) begin
        if (rd_take) begin
            rd_pend_sel <= i_rd_req.sel;
        end
    end

    // slave data registers only move on an enable, so they hold under stall
    always_comb begin
        if (rd_pend_sel[SEL_REG]) begin
            o_rsp_rd.data = i_reg_rdata;
        end else if (rd_pend_sel[SEL_ROM]) begin
            o_rsp_rd.data = i_rom_rdata;
        end else begin
            o_rsp_rd.data = '0;
        end
        o_rsp_rd.resp = rd_pend_sel[SEL_NONE] ? RESP_DECERR : RESP_OKAY;
    end

    ////////////////////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////////////////////

    logic wr_free;
    logic wr_needs_bank;
    logic wr_take;

    assign wr_free       = !o_bvalid || i_bready;
    assign wr_needs_bank = i_wr_req.sel[SEL_REG];

    // the word index is shared, a slave read this cycle holds off a bank write
    assign o_wr_ready = wr_free && !(wr_needs_bank && rd_busy);
    assign wr_take    = i_wr_valid && o_wr_ready;

    assign o_reg_wr_en = wr_take && wr_needs_bank && i_wr_req.req.write;

    always_ff @(posedge clock) begin
        if (reset) begin
            o_bvalid <= 1'b0;
        end else if (wr_free) begin
            o_bvalid <= wr_take;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_take) begin
            o_bresp <= i_wr_req.sel[SEL_NONE] ? RESP_DECERR : RESP_OKAY;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shared slave bus
    ////////////////////////////////////////////////////////////////////////////

    // read owns the index when it drives an enable
    assign o_word_sel = rd_busy ? i_rd_req.req.addr[WORD_LSB +: WORD_SEL_W]
                                : i_wr_req.req.addr[WORD_LSB +: WORD_SEL_W];
    assign o_wdata    = i_wr_req.req.wdata;
    assign o_wstrb    = i_wr_req.req.wstrb;

endmodule

// ==== hdl/axil_reg_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// eight 32-bit read-write registers with byte strobes and registered reads
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_reg_bank
    import axil_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  i_wr_en,
    input  logic                  i_rd_en,
    input  logic [WORD_SEL_W-1:0] i_word_sel,
    input  data_t                 i_wdata,
    input  strb_t                 i_wstrb,
    output data_t                 o_rdata
);

    localparam int NUM_WORDS = 1 << WORD_SEL_W;
    localparam int NUM_BYTES = $bits(strb_t);

    // register storage
    data_t regs [NUM_WORDS];

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                regs[w] <= '0;
            end
        end else if (i_wr_en) begin
            // only strobed bytes change
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (i_wstrb[b]) begin
                    regs[i_word_sel][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    // data appears one cycle after the enable and holds until the next one
    always_ff @(posedge clock) begin
        if (i_rd_en) begin
            o_rdata <= regs[i_word_sel];
        end
    end

endmodule

// ==== hdl/axil_id_rom.sv ====
////////////////////////////////////////////////////////////////////////////
// read-only identification words, word i holds the tag plus i
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_id_rom
    import axil_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  i_rd_en,
    input  logic [WORD_SEL_W-1:0] i_word_sel,
    output data_t                 o_rdata
);

    data_t rom_word;

    // tag in the upper bits, index in the low bits
    assign rom_word = ROM_TAG + data_t'(i_word_sel);

    // registered read, held between enables
    always_ff @(posedge clock) begin
        if (i_rd_en) begin
            o_rdata <= rom_word;
        end
    end

endmodule

// ==== hdl/axil_periph_top.sv ====
////////////////////////////////////////////////////////////////////////////
// axi4-lite peripheral top, decode and route stages per channel in front
// of a register bank and an identification rom
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_periph_top
    import axil_map_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // write address / data
    input  addr_t i_awaddr,
    input  logic  i_awvalid,
    output logic  o_awready,
    input  data_t i_wdata,
    input  strb_t i_wstrb,
    input  logic  i_wvalid,
    output logic  o_wready,

    // write response
    output resp_t o_bresp,
    output logic  o_bvalid,
    input  logic  i_bready,

    // read address
    input  addr_t i_araddr,
    input  logic  i_arvalid,
    output logic  o_arready,

    // read data
    output data_t o_rdata,
    output resp_t o_rresp,
    output logic  o_rvalid,
    input  logic  i_rready
);

    req_t     rd_req;
    req_t     wr_req;
    logic     wr_in_valid;
    logic     wr_in_ready;
    logic     rd_dec_valid;
    logic     rd_dec_ready;
    dec_req_t rd_dec_req;
    logic     wr_dec_valid;
    logic     wr_dec_ready;
    dec_req_t wr_dec_req;
    rsp_t     rd_rsp;

    logic                  reg_wr_en;
    logic                  reg_rd_en;
    logic                  rom_rd_en;
    logic [WORD_SEL_W-1:0] word_sel;
    data_t                 slv_wdata;
    strb_t                 slv_wstrb;
    data_t                 reg_rdata;
    data_t                 rom_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // pack the axi channels
    ////////////////////////////////////////////////////////////////////////////

    assign rd_req = '{addr: i_araddr, wdata: '0, wstrb: '0, write: 1'b0};
    assign wr_req = '{addr: i_awaddr, wdata: i_wdata, wstrb: i_wstrb, write: 1'b1};

    // address and data are taken together
    assign wr_in_valid = i_awvalid && i_wvalid;
    assign o_awready   = wr_in_valid && wr_in_ready;
    assign o_wready    = wr_in_valid && wr_in_ready;

    assign o_rdata = rd_rsp.data;
    assign o_rresp = rd_rsp.resp;

    ////////////////////////////////////////////////////////////////////////////
    // decode stages
    ////////////////////////////////////////////////////////////////////////////

    axil_addr_decode #(
        .ACCESS_ALLOWED (READ_ALLOWED)
    ) rd_decode0 (
        .clock   (clock),
        .reset   (reset),
        .i_valid (i_arvalid),
        .o_ready (o_arready),
        .i_req   (rd_req),
        .o_valid (rd_dec_valid),
        .i_ready (rd_dec_ready),
        .o_req   (rd_dec_req)
    );

    axil_addr_decode #(
        .ACCESS_ALLOWED (WRITE_ALLOWED)
    ) wr_decode0 (
        .clock   (clock),
        .reset   (reset),
        .i_valid (wr_in_valid),
        .o_ready (wr_in_ready),
        .i_req   (wr_req),
        .o_valid (wr_dec_valid),
        .i_ready (wr_dec_ready),
        .o_req   (wr_dec_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // router and slaves
    ////////////////////////////////////////////////////////////////////////////

    axil_router router0 (
        .clock       (clock),
        .reset       (reset),
        .i_rd_valid  (rd_dec_valid),
        .o_rd_ready  (rd_dec_ready),
        .i_rd_req    (rd_dec_req),
        .i_wr_valid  (wr_dec_valid),
        .o_wr_ready  (wr_dec_ready),
        .i_wr_req    (wr_dec_req),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_rsp_rd    (rd_rsp),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_bresp     (o_bresp),
        .o_reg_wr_en (reg_wr_en),
        .o_reg_rd_en (reg_rd_en),
        .o_rom_rd_en (rom_rd_en),
        .o_word_sel  (word_sel),
        .o_wdata     (slv_wdata),
        .o_wstrb     (slv_wstrb),
        .i_reg_rdata (reg_rdata),
        .i_rom_rdata (rom_rdata)
    );

    axil_reg_bank regs0 (
        .clock      (clock),
        .reset      (reset),
        .i_wr_en    (reg_wr_en),
        .i_rd_en    (reg_rd_en),
        .i_word_sel (word_sel),
        .i_wdata    (slv_wdata),
        .i_wstrb    (slv_wstrb),
        .o_rdata    (reg_rdata)
    );

    axil_id_rom rom0 (
        .clock      (clock),
        .i_rd_en    (rom_rd_en),
        .i_word_sel (word_sel),
        .o_rdata    (rom_rdata)
    );

endmodule

// ==== tests/axil_periph_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// response checker that captures every handshake into ordered queues and
// compares each response against a register bank model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module axil_periph_checker
    import axil_map_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t i_awaddr,
    input  logic  i_awvalid,
    input  logic  i_awready,
    input  data_t i_wdata,
    input  strb_t i_wstrb,
    input  logic  i_wvalid,
    input  logic  i_wready,
    input  resp_t i_bresp,
    input  logic  i_bvalid,
    input  logic  i_bready,
    input  addr_t i_araddr,
    input  logic  i_arvalid,
    input  logic  i_arready,
    input  data_t i_rdata,
    input  resp_t i_rresp,
    input  logic  i_rvalid,
    input  logic  i_rready,
    output int    o_mismatch_count,
    output int    o_failure_count,
    output int    o_pending_count
);

    // eight-word image of the register bank
    data_t model [8];
    // expected responses with the oldest at the front
    rsp_t  rd_expect [$];
    resp_t wr_expect [$];
    logic  reset_q;
    // read latency tracking with one flag per pipeline stage
    logic  rd_lat1;
    logic  rd_lat2;

    // a 4 KiB window matches on the upper twenty address bits
    function automatic logic in_window(input addr_t addr, input addr_t base);
        return addr[31:12] == base[31:12];
    endfunction

    always @(posedge clock) begin : watch
        int    idx;
        rsp_t  want;
        rsp_t  got;
        resp_t want_b;
        if (reset) begin
            for (int w = 0; w < 8; w++) begin
                model[w] = '0;
            end
            rd_expect.delete();
            wr_expect.delete();
            rd_lat1 = 1'b0;
            rd_lat2 = 1'b0;
            o_mismatch_count = 0;
            o_failure_count = 0;
        end else begin
            // on the first edge after reset the response channels are idle
            // and reads are open
            if (reset_q && (i_rvalid !== 1'b0 || i_bvalid !== 1'b0 || i_arready !== 1'b1)) begin
                $display("at %0t: rvalid, bvalid or arready wrong right after reset", $time);
                o_failure_count++;
            end
            ////////////////////////////////////////////////////////////////////////////
            // read latency
            ////////////////////////////////////////////////////////////////////////////
            // a read whose router stage was free must show rvalid two edges later
            if (rd_lat2 && !i_rvalid) begin
                $display("at %0t: read response missing two cycles after its handshake", $time);
                o_failure_count++;
            end
            rd_lat2 = rd_lat1 && (!i_rvalid || i_rready);
            rd_lat1 = i_arvalid && i_arready;
            ////////////////////////////////////////////////////////////////////////////
            // requests
            ////////////////////////////////////////////////////////////////////////////
            if (i_arvalid && i_arready) begin
                idx = i_araddr[4:2];
                if (in_window(i_araddr, REG_BASE)) begin
                    want.data = model[idx];
                    want.resp = RESP_OKAY;
                end else if (in_window(i_araddr, ROM_BASE)) begin
                    want.data = ROM_TAG + data_t'(idx);
                    want.resp = RESP_OKAY;
                end else begin
                    want.data = '0;
                    want.resp = RESP_DECERR;
                end
                rd_expect.push_back(want);
            end
            // write address and write data move on the same edge
            if ((i_awvalid && i_awready) != (i_wvalid && i_wready)) begin
                $display("at %0t: write address and write data accepted apart", $time);
                o_failure_count++;
            end
            if (i_awvalid && i_awready) begin
                // the rom is read-only, so only the bank window answers okay
                if (in_window(i_awaddr, REG_BASE)) begin
                    idx = i_awaddr[4:2];
                    for (int b = 0; b < 4; b++) begin
                        if (i_wstrb[b]) begin
                            model[idx][8*b +: 8] = i_wdata[8*b +: 8];
                        end
                    end
                    wr_expect.push_back(RESP_OKAY);
                end else begin
                    wr_expect.push_back(RESP_DECERR);
                end
            end
            ////////////////////////////////////////////////////////////////////////////
            // responses
            ////////////////////////////////////////////////////////////////////////////
            if (i_bvalid && i_bready) begin
                if (wr_expect.size() == 0) begin
                    $display("at %0t: write response with no write outstanding", $time);
                    o_failure_count++;
                end else begin
                    want_b = wr_expect.pop_front();
                    if (i_bresp !== want_b) begin
                        $display("mismatch at %0t: bresp %0d, expected %0d",
                                 $time, i_bresp, want_b);
                        o_mismatch_count++;
                    end
                end
            end
            if (i_rvalid && i_rready) begin
                if (rd_expect.size() == 0) begin
                    $display("at %0t: read response with no read outstanding", $time);
                    o_failure_count++;
                end else begin
                    want = rd_expect.pop_front();
                    got.data = i_rdata;
                    got.resp = i_rresp;
                    if (got !== want) begin
                        $display("mismatch at %0t: rdata %h rresp %0d, expected %h rresp %0d",
                                 $time, got.data, got.resp, want.data, want.resp);
                        o_mismatch_count++;
                    end
                end
            end
        end
        reset_q = reset;
        o_pending_count = rd_expect.size() + wr_expect.size();
    end

endmodule

// ==== tests/tb_axil_periph.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the axi4-lite peripheral, random master with ready noise
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_axil_periph
    import axil_map_pkg::*;
();

    localparam int NUM_TXN        = 400;
    localparam int CYCLES_PER_TXN = 12;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_TXN * CYCLES_PER_TXN + RESET_CYCLES;
    localparam int SEED           = 84123;
    // percent of cycles with bready / rready high
    localparam int READY_PCT      = 70;

    logic  clock = 1'b0;
    logic  reset;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;
    int    mismatch_count;
    int    failure_count;
    int    pending_count;
    int    cycle_count = 0;

    // 8 ns period
    always #4 clock = ~clock;

    axil_periph_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .i_awaddr  (awaddr),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_wdata   (wdata),
        .i_wstrb   (wstrb),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bresp   (bresp),
        .o_bvalid  (bvalid),
        .i_bready  (bready),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_rdata   (rdata),
        .o_rresp   (rresp),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    axil_periph_checker checker0 (
        .clock            (clock),
        .reset            (reset),
        .i_awaddr         (awaddr),
        .i_awvalid        (awvalid),
        .i_awready        (awready),
        .i_wdata          (wdata),
        .i_wstrb          (wstrb),
        .i_wvalid         (wvalid),
        .i_wready         (wready),
        .i_bresp          (bresp),
        .i_bvalid         (bvalid),
        .i_bready         (bready),
        .i_araddr         (araddr),
        .i_arvalid        (arvalid),
        .i_arready        (arready),
        .i_rdata          (rdata),
        .i_rresp          (rresp),
        .i_rvalid         (rvalid),
        .i_rready         (rready),
        .o_mismatch_count (mismatch_count),
        .o_failure_count  (failure_count),
        .o_pending_count  (pending_count)
    );

    // kind 0 and 1 hit the bank, 2 the rom, 3 unmapped space
    function automatic addr_t pick_addr(input int kind);
        addr_t offs;
        offs = $urandom() & 32'h0000_0FFC;
        case (kind)
            0, 1:    return REG_BASE | offs;
            2:       return ROM_BASE | offs;
            default: return 32'h4000_0000 | ($urandom() & 32'h0FFF_FFFC);
        endcase
    endfunction

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d responses missing",
                 mismatch_count, failure_count, pending_count);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run limit
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random master
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int    issued;
        int    wr_out;
        int    rd_out;
        int    reg_rd_out;
        int    kind;
        logic  ar_fire;
        logic  aw_fire;
        logic  r_fire;
        logic  b_fire;
        logic  rd_is_reg [$];
        void'($urandom(SEED));
        issued = 0;
        wr_out = 0;
        rd_out = 0;
        reg_rd_out = 0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        while (issued < NUM_TXN || wr_out > 0 || rd_out > 0) begin
            // handshakes of the coming edge, inputs are stable here
            @(posedge clock);
            ar_fire = arvalid && arready;
            aw_fire = awvalid && awready;
            r_fire  = rvalid && rready;
            b_fire  = bvalid && bready;
            @(negedge clock);
            if (ar_fire) begin
                arvalid = 1'b0;
            end
            if (aw_fire) begin
                awvalid = 1'b0;
                wvalid = 1'b0;
            end
            if (b_fire) begin
                wr_out--;
            end
            if (r_fire) begin
                rd_out--;
                if (rd_is_reg.pop_front()) begin
                    reg_rd_out--;
                end
            end
            bready = ($urandom_range(99) < READY_PCT);
            rready = ($urandom_range(99) < READY_PCT);
            // the bank has no ordering between channels, so bank reads and
            // writes never overlap
            if (!arvalid && issued < NUM_TXN && $urandom_range(1) == 1) begin
                kind = $urandom_range(3);
                if (!(kind <= 1 && wr_out > 0)) begin
                    araddr = pick_addr(kind);
                    arvalid = 1'b1;
                    rd_is_reg.push_back(kind <= 1);
                    if (kind <= 1) begin
                        reg_rd_out++;
                    end
                    rd_out++;
                    issued++;
                end
            end
            if (!awvalid && issued < NUM_TXN && $urandom_range(1) == 1) begin
                kind = $urandom_range(3);
                if (!(kind <= 1 && reg_rd_out > 0)) begin
                    awaddr = pick_addr(kind);
                    wdata = $urandom();
                    wstrb = strb_t'($urandom_range(15));
                    awvalid = 1'b1;
                    wvalid = 1'b1;
                    wr_out++;
                    issued++;
                end
            end
        end
        // a few idle cycles to catch stray responses
        bready = 1'b1;
        rready = 1'b1;
        repeat (4) @(negedge clock);
        report_counts();
        if (mismatch_count == 0 && failure_count == 0 && pending_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== axil_periph_top.f ====
common/axil_map_pkg.sv
hdl/axil_addr_decode.sv
axil_router/axil_router.sv
hdl/axil_reg_bank.sv
hdl/axil_id_rom.sv
hdl/axil_periph_top.sv
tests/axil_periph_checker.sv
tests/tb_axil_periph.sv
